// ==== bench/tb_model.svh ====
//==========================================================================
// execute stage reference model
// galois lfsr random source plus the expected-result rules for one beat,
// with its own address buffer and iota count
//==========================================================================
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef struct packed {
  logic              load;
  logic              store;
  logic [WORD_W-1:0] res0;
  logic [WORD_W-1:0] res1;
  logic [1:0]        wen;
  offset_t           woff0;
  offset_t           woff1;
} expect_t;

logic [31:0]       lfsr_state = 32'h0dca1f60;
logic [WORD_W-1:0] model_addr_buf = '0;
logic [WORD_W-1:0] model_iota_cnt = '0;

// one lfsr step for each bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    if (lfsr_state[0]) begin
      lfsr_state = (lfsr_state >> 1) ^ 32'hA3000000;
    end else begin
      lfsr_state = lfsr_state >> 1;
    end
    v = {v[30:0], lfsr_state[0]};
  end
  return v;
endfunction

function automatic logic [WORD_W-1:0] operand(input src_t s, input logic [WORD_W-1:0] vreg,
                                              input logic [WORD_W-1:0] sreg,
                                              input logic [WORD_W-1:0] immv);
  if (s == V) begin
    return vreg;
  end
  if (s == I) begin
    return immv;
  end
  if (s == X) begin
    return sreg;
  end
  return '0;
endfunction

// a is the vs2 operand, b the vs1 operand
function automatic logic [WORD_W-1:0] alu_ref(input aluop_t op, input logic [WORD_W-1:0] a,
                                              input logic [WORD_W-1:0] b);
  case (op)
    ADD: return a + b;
    SUB: return a - b;
    AND: return a & b;
    OR:  return a | b;
    XOR: return a ^ b;
    SLL: return a << b[4:0];
    SRL: return a >> b[4:0];
    MIN: return ($signed(a) < $signed(b)) ? a : b;
    MAX: return ($signed(a) < $signed(b)) ? b : a;
    default: return '0;
  endcase
endfunction

// expected latch contents of the beat now on the inputs, model state advanced
function automatic expect_t build_expect();
  expect_t           e;
  logic [WORD_W-1:0] a0, a1, b0, b1, step, ad0, ad1, l0, l1, base;
  logic              first;
  first = woffset0 == '0;
  b0    = operand(rs1_type, vs1_lane0, xs1, imm);
  b1    = operand(rs1_type, vs1_lane1, xs1, imm);
  a0    = operand(rs2_type, vs2_lane0, xs2, imm);
  a1    = operand(rs2_type, vs2_lane1, xs2, imm);
  step  = stride_type ? stride_val : 32'd4;
  ad0   = first ? xs1 : model_addr_buf + step;
  ad1   = ad0 + step;
  base  = first ? '0 : model_iota_cnt;
  case (fu_type)
    MUL: begin
      l0 = a0 * b0;
      l1 = a1 * b1;
    end
    MASK: begin
      l0 = base;
      l1 = base + WORD_W'(a0[0]);
    end
    LSU: begin
      l0 = ad0;
      l1 = ad1;
    end
    default: begin
      l0 = alu_ref(aluop, a0, b0);
      l1 = alu_ref(aluop, a1, b1);
    end
  endcase
  if (fu_type == MASK) begin
    model_iota_cnt = base + WORD_W'(a0[0]) + WORD_W'(a1[0]);
  end
  if (load || store) begin
    model_addr_buf = ad1;
  end
  e.load  = load;
  e.store = store;
  e.res0  = (load || store) ? ad0 : (reduction_ena ? l0 + l1 : l0);
  e.res1  = (load || store) ? ad1 : l1;
  e.wen   = wen;
  e.woff0 = woffset0;
  e.woff1 = woffset1;
  return e;
endfunction

`endif

// ==== bench/tb_rv32v_execute_stage.sv ====
//==========================================================================
// execute stage testbench
// random beats with stall and flush, checked against a reference model
//==========================================================================
`timescale 1ns/1ps

module tb_rv32v_execute_stage;
  import rv32v_pkg::*;

  localparam int NUM_BEATS   = 600;
  localparam int CYCLE_LIMIT = NUM_BEATS * MUL_CYCLES * 2 + 200;

  logic CLK, nRST, in_valid, stride_type, load, store, reduction_ena;
  logic stall_ex, flush_ex, busy_ex, out_valid, out_load, out_store;
  fu_t fu_type;
  aluop_t aluop;
  src_t rs1_type, rs2_type;
  logic [WORD_W-1:0] vs1_lane0, vs1_lane1, vs2_lane0, vs2_lane1;
  logic [WORD_W-1:0] imm, xs1, xs2, stride_val, aluresult0, aluresult1;
  offset_t woffset0, woffset1, out_woffset0, out_woffset1;
  logic [1:0] wen, out_wen;

  int errors = 0;
  int cycles = 0;
  int beats = 0;
  int mul_cnt = 0;
  logic finished = 1'b0;
  logic mul_pend = 1'b0;
  logic mul_hold_m = 1'b0;
  logic wait_mul = 1'b0;
  logic last_stall = 1'b0;
  logic last_flush = 1'b0;
  logic last_valid = 1'b0;

  `include "tb_model.svh"

  expect_t exp_q[$];
  expect_t mul_entry;
  expect_t last_out;

  rv32v_execute_stage rv32v_execute_stage_inst (.*);

  always #2 CLK = ~CLK;

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic drive_new_beat();
    logic [31:0] r;
    fu_t f;
    r = rand_bits(2);
    f = fu_t'(r[1:0]);
    fu_type <= f;
    r = rand_bits(4);
    aluop <= aluop_t'(r[3:0] % 4'd9);
    r = rand_bits(2);
    rs1_type <= src_t'(r[1:0]);
    r = rand_bits(2);
    rs2_type <= src_t'(r[1:0]);
    vs1_lane0  <= rand_bits(32);
    vs1_lane1  <= rand_bits(32);
    vs2_lane0  <= rand_bits(32);
    vs2_lane1  <= rand_bits(32);
    imm        <= rand_bits(32);
    xs1        <= rand_bits(32);
    xs2        <= rand_bits(32);
    stride_val <= rand_bits(32);
    r = rand_bits(1);
    stride_type <= r[0];
    // about one beat in four starts a new register group
    r = rand_bits(2);
    if (r[1:0] == 2'd0) begin
      woffset0 <= '0;
    end else begin
      r = rand_bits(5);
      woffset0 <= r[4:0];
    end
    r = rand_bits(5);
    woffset1 <= r[4:0];
    r = rand_bits(2);
    wen <= r[1:0];
    r = rand_bits(1);
    load  <= (f == LSU) && !r[0];
    store <= (f == LSU) && r[0];
    r = rand_bits(2);
    reduction_ena <= (f != LSU) && (r[1:0] == 2'd0);
    r = rand_bits(2);
    in_valid <= r[1:0] != 2'd0;
  endtask

  always @(posedge CLK) begin : step_blk
    logic acc, busy_m, fresh;
    logic [31:0] r;
    expect_t e;
    expect_t seen;
    if (nRST) begin
      cycles++;
      busy_m = (mul_cnt > 0) || mul_hold_m;
      compare_word("busy_ex", 32'(busy_ex), 32'(busy_m));
      seen.load  = out_load;
      seen.store = out_store;
      seen.res0  = aluresult0;
      seen.res1  = aluresult1;
      seen.wen   = out_wen;
      seen.woff0 = out_woffset0;
      seen.woff1 = out_woffset1;
      // outputs written by the previous edge
      fresh = !last_stall || last_flush;
      if (fresh) begin
        if (exp_q.size() > 0) begin
          e = exp_q.pop_front();
          if (out_valid !== 1'b1) begin
            $display("[FAIL] out_valid got %h expected 1", out_valid);
            errors++;
          end else begin
            compare_word("out_load", 32'(out_load), 32'(e.load));
            compare_word("out_store", 32'(out_store), 32'(e.store));
            compare_word("aluresult0", aluresult0, e.res0);
            compare_word("aluresult1", aluresult1, e.res1);
            compare_word("out_wen", 32'(out_wen), 32'(e.wen));
            compare_word("out_woffset0", 32'(out_woffset0), 32'(e.woff0));
            compare_word("out_woffset1", 32'(out_woffset1), 32'(e.woff1));
          end
        end else if (out_valid !== 1'b0) begin
          $display("out_valid went high with no result expected at cycle %0d", cycles);
          errors++;
        end
      end else if (out_valid !== last_valid || seen !== last_out) begin
        $display("latch outputs changed during a stall at cycle %0d", cycles);
        errors++;
      end

      // multiply in flight, done at the edge where the count reaches one
      if (mul_cnt > 0) begin
        if (mul_cnt == 1 && mul_pend && !flush_ex) begin
          if (stall_ex) begin
            mul_hold_m = 1'b1;
          end else begin
            exp_q.push_back(mul_entry);
          end
        end
        if (flush_ex) begin
          mul_pend = 1'b0;
        end
        mul_cnt--;
      end else if (mul_hold_m) begin
        if (flush_ex) begin
          mul_hold_m = 1'b0;
        end else if (!stall_ex) begin
          exp_q.push_back(mul_entry);
          mul_hold_m = 1'b0;
        end
      end

      acc = in_valid && !stall_ex && !busy_m;
      if (acc) begin
        beats++;
        e = build_expect();
        if (fu_type == MUL) begin
          mul_entry = e;
          mul_pend  = !flush_ex;
          mul_cnt   = MUL_CYCLES - 1;
        end else if (!flush_ex) begin
          exp_q.push_back(e);
        end
      end

      last_stall = stall_ex;
      last_flush = flush_ex;
      last_valid = out_valid;
      last_out   = seen;

      // multiply beat stays on the inputs until the result is latched
      if (acc && fu_type == MUL) begin
        wait_mul = 1'b1;
      end else if (wait_mul) begin
        if (mul_cnt == 0 && !mul_hold_m) begin
          wait_mul = 1'b0;
          drive_new_beat();
        end
      end else if (acc || !in_valid) begin
        drive_new_beat();
      end
      if (beats >= NUM_BEATS) begin
        in_valid <= 1'b0;
      end
      r = rand_bits(3);
      stall_ex <= r[2:0] == 3'd0;
      r = rand_bits(5);
      flush_ex <= r[4:0] == 5'd0;

      if (beats >= NUM_BEATS && mul_cnt == 0 && !mul_hold_m && exp_q.size() == 0) begin
        finished = 1'b1;
      end
    end
  end

  initial begin
    CLK = 1'b0;
    nRST = 1'b0;
    in_valid = 1'b0;
    fu_type = ALU;
    aluop = ADD;
    rs1_type = V;
    rs2_type = V;
    vs1_lane0 = '0;
    vs1_lane1 = '0;
    vs2_lane0 = '0;
    vs2_lane1 = '0;
    imm = '0;
    xs1 = '0;
    xs2 = '0;
    stride_type = 1'b0;
    stride_val = '0;
    load = 1'b0;
    store = 1'b0;
    woffset0 = '0;
    woffset1 = '0;
    wen = '0;
    reduction_ena = 1'b0;
    stall_ex = 1'b0;
    flush_ex = 1'b0;
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    if (out_valid !== 1'b0 || out_load !== 1'b0 || out_store !== 1'b0 ||
        out_wen !== 2'b00 || busy_ex !== 1'b0) begin
      $display("control outputs not low after reset");
      errors++;
    end
    wait (finished || cycles >= CYCLE_LIMIT);
    if (!finished) begin
      $display("timeout after %0d cycles with %0d beats accepted", cycles, beats);
      errors++;
    end
    $display("errors: %0d after %0d beats", errors, beats);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== design/iota_logic.sv ====
//==========================================================================
// iota logic
// running prefix count of mask bits across beats, two elements a beat
//==========================================================================
`timescale 1ns/1ps

module iota_logic (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          start,
  input  logic                          advance,
  input  logic [1:0]                    mask_bits,
  output logic [rv32v_pkg::WORD_W-1:0]  res0,
  output logic [rv32v_pkg::WORD_W-1:0]  res1
);
  import rv32v_pkg::*;

  logic [WORD_W-1:0] count;
  logic [WORD_W-1:0] base;
  logic [WORD_W-1:0] next_count;

  // a first beat sees zero regardless of what is left over
  assign base = start ? '0 : count;

  // lane 0 counts the bits before it, lane 1 also its neighbour
  assign res0 = base;
  assign res1 = base + WORD_W'(mask_bits[0]);

  assign next_count = res1 + WORD_W'(mask_bits[1]);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else if (advance) begin
      count <= next_count;
    end
  end

endmodule

// ==== design/lane_multiplier.sv ====
//==========================================================================
// lane multiplier
// 32x32 low-word multiply, one operand slice summed per cycle;
// done marks the cycle in which product is valid
//==========================================================================
`timescale 1ns/1ps

module lane_multiplier (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          start,
  input  logic [rv32v_pkg::WORD_W-1:0]  a,
  input  logic [rv32v_pkg::WORD_W-1:0]  b,
  output logic [rv32v_pkg::WORD_W-1:0]  product,
  output logic                          busy,
  output logic                          done
);
  import rv32v_pkg::*;

  logic [MUL_CNT_W-1:0] stage;
  logic [WORD_W-1:0]    acc;
  logic [WORD_W-1:0]    a_sh;
  logic [WORD_W-1:0]    b_sh;
  logic [WORD_W-1:0]    op_a;
  logic [WORD_W-1:0]    op_b;
  logic [WORD_W-1:0]    partial;

  // first slice comes straight from the inputs on the start cycle
  assign op_a    = busy ? a_sh : a;
  assign op_b    = busy ? b_sh : b;
  assign partial = op_a * WORD_W'(op_b[MUL_CHUNK_W-1:0]);

  assign busy    = stage != '0;
  assign done    = stage == MUL_CNT_W'(MUL_CYCLES - 1);
  // last slice added combinationally
  assign product = acc + partial;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      stage <= '0;
    end else if (start) begin
      stage <= MUL_CNT_W'(1);
    end else if (done) begin
      stage <= '0;
    end else if (busy) begin
      stage <= stage + MUL_CNT_W'(1);
    end
  end

  // accumulator and shifted operands only advance before the done cycle
  always_ff @(posedge CLK) begin
    if (start || (busy && !done)) begin
      acc  <= (busy ? acc : '0) + partial;
      a_sh <= op_a << MUL_CHUNK_W;
      b_sh <= op_b >> MUL_CHUNK_W;
    end
  end

  // the stage must keep a new multiply out until this one finishes
  a_no_start_busy : assert property (@(posedge CLK) disable iff (!nRST) start |-> !busy);

endmodule

// ==== design/rv32v_execute_stage.sv ====
//==========================================================================
// rv32v execute stage
// operand select, two vector lanes, address chaining, iota and
// reduction fold into the execute-to-memory latch under stall and flush
//==========================================================================
`timescale 1ns/1ps

module rv32v_execute_stage (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          in_valid,
  input  rv32v_pkg::fu_t                fu_type,
  input  rv32v_pkg::aluop_t             aluop,
  input  rv32v_pkg::src_t               rs1_type,
  input  rv32v_pkg::src_t               rs2_type,
  input  logic [rv32v_pkg::WORD_W-1:0]  vs1_lane0,
  input  logic [rv32v_pkg::WORD_W-1:0]  vs1_lane1,
  input  logic [rv32v_pkg::WORD_W-1:0]  vs2_lane0,
  input  logic [rv32v_pkg::WORD_W-1:0]  vs2_lane1,
  input  logic [rv32v_pkg::WORD_W-1:0]  imm,
  input  logic [rv32v_pkg::WORD_W-1:0]  xs1,
  input  logic [rv32v_pkg::WORD_W-1:0]  xs2,
  input  logic                          stride_type,
  input  logic [rv32v_pkg::WORD_W-1:0]  stride_val,
  input  logic                          load,
  input  logic                          store,
  input  rv32v_pkg::offset_t            woffset0,
  input  rv32v_pkg::offset_t            woffset1,
  input  logic [1:0]                    wen,
  input  logic                          reduction_ena,
  input  logic                          stall_ex,
  input  logic                          flush_ex,
  output logic                          busy_ex,
  output logic                          out_valid,
  output logic                          out_load,
  output logic                          out_store,
  output logic [rv32v_pkg::WORD_W-1:0]  aluresult0,
  output logic [rv32v_pkg::WORD_W-1:0]  aluresult1,
  output logic [1:0]                    out_wen,
  output rv32v_pkg::offset_t            out_woffset0,
  output rv32v_pkg::offset_t            out_woffset1
);
  import rv32v_pkg::*;

  logic [WORD_W-1:0] vs1_op0, vs1_op1, vs2_op0, vs2_op1;
  logic [WORD_W-1:0] addr_step, step0, base0, addr_buffer;
  logic [WORD_W-1:0] addr0, addr1, lane_res0, lane_res1;
  logic [WORD_W-1:0] iota0, iota1, sel0, sel1, res0;
  logic [WORD_W-1:0] hold_res0, hold_res1;
  logic busy0, busy1, done0, done1;
  logic accept, is_mul, is_mask, ls, first_beat, start_mul;
  logic mul_live, mul_take, mul_hold, latch_load;

  function automatic logic [WORD_W-1:0] pick_operand(
    input src_t              sel,
    input logic [WORD_W-1:0] vreg,
    input logic [WORD_W-1:0] sreg,
    input logic [WORD_W-1:0] immv
  );
    case (sel)
      V:       return vreg;
      I:       return immv;
      X:       return sreg;
      default: return '0;
    endcase
  endfunction

  assign vs1_op0 = pick_operand(rs1_type, vs1_lane0, xs1, imm);
  assign vs1_op1 = pick_operand(rs1_type, vs1_lane1, xs1, imm);
  assign vs2_op0 = pick_operand(rs2_type, vs2_lane0, xs2, imm);
  assign vs2_op1 = pick_operand(rs2_type, vs2_lane1, xs2, imm);

  assign is_mul     = fu_type == MUL;
  assign is_mask    = fu_type == MASK;
  assign ls         = load | store;
  assign first_beat = woffset0 == '0;
  // a result held under stall still counts as busy
  assign busy_ex    = busy0 | busy1 | mul_hold;
  assign accept     = in_valid & ~stall_ex & ~busy_ex;
  assign start_mul  = accept & is_mul;

  // unit stride steps one element, a first beat starts at xs1 itself
  assign addr_step = stride_type ? stride_val : WORD_W'(WORD_W / 8);
  assign base0     = first_beat ? xs1 : addr_buffer;
  assign step0     = first_beat ? '0 : addr_step;

  vector_lane lane0 (
    .CLK(CLK), .nRST(nRST), .fu_type(fu_type), .aluop(aluop), .start_mul(start_mul),
    .vs1_data(vs1_op0), .vs2_data(vs2_op0), .addr_base(base0), .addr_step(step0),
    .iota_res(iota0), .out_addr(addr0), .lane_result(lane_res0),
    .mul_busy(busy0), .mul_done(done0)
  );

  vector_lane lane1 (
    .CLK(CLK), .nRST(nRST), .fu_type(fu_type), .aluop(aluop), .start_mul(start_mul),
    .vs1_data(vs1_op1), .vs2_data(vs2_op1), .addr_base(addr0), .addr_step(addr_step),
    .iota_res(iota1), .out_addr(addr1), .lane_result(lane_res1),
    .mul_busy(busy1), .mul_done(done1)
  );

  iota_logic iota (
    .CLK(CLK), .nRST(nRST), .start(is_mask & first_beat), .advance(accept & is_mask),
    .mask_bits({vs2_op1[0], vs2_op0[0]}), .res0(iota0), .res1(iota1)
  );

  // memory beats carry addresses, reduction folds both lanes into element 0
  assign sel0 = ls ? addr0 : lane_res0;
  assign sel1 = ls ? addr1 : lane_res1;
  assign res0 = reduction_ena ? lane_res0 + lane_res1 : sel0;

  assign mul_take   = done0 & done1 & mul_live;
  assign latch_load = ~stall_ex & (mul_hold | mul_take | (accept & ~is_mul));

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      addr_buffer <= '0;
      mul_live    <= 1'b0;
      mul_hold    <= 1'b0;
    end else begin
      if (accept && ls) begin
        addr_buffer <= addr1;
      end
      if (flush_ex || (done0 && !start_mul)) begin
        mul_live <= 1'b0;
      end else if (start_mul) begin
        mul_live <= 1'b1;
      end
      if (flush_ex || !stall_ex) begin
        mul_hold <= 1'b0;
      end else if (mul_take) begin
        mul_hold <= 1'b1;
      end
    end
  end

  // multiply result parked while the latch is stalled
  always_ff @(posedge CLK) begin
    if (mul_take && stall_ex) begin
      hold_res0 <= res0;
      hold_res1 <= sel1;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
      out_load  <= 1'b0;
      out_store <= 1'b0;
      out_wen   <= '0;
    end else if (flush_ex) begin
      out_valid <= 1'b0;
      out_load  <= 1'b0;
      out_store <= 1'b0;
      out_wen   <= '0;
    end else if (!stall_ex) begin
      out_valid <= latch_load;
      out_load  <= latch_load & load;
      out_store <= latch_load & store;
      out_wen   <= latch_load ? wen : '0;
    end
  end

  always_ff @(posedge CLK) begin
    if (latch_load) begin
      aluresult0   <= mul_hold ? hold_res0 : res0;
      aluresult1   <= mul_hold ? hold_res1 : sel1;
      out_woffset0 <= woffset0;
      out_woffset1 <= woffset1;
    end
  end

  a_ld_st_excl : assert property (@(posedge CLK) disable iff (!nRST)
    in_valid |-> !(load && store));
  a_flush_empty : assert property (@(posedge CLK) disable iff (!nRST)
    flush_ex |=> !out_valid);

endmodule

// ==== design/rv32v_pkg.sv ====
//==========================================================================
// rv32v execute types
// operation codes, operand sources and widths shared by the two-lane
// vector execute stage and its lanes
//==========================================================================

package rv32v_pkg;

  // element and address width
  localparam int WORD_W = 32;

  // element write offset width
  localparam int OFFSET_W = 5;

  // multiplier latency in cycles, start edge included
  localparam int MUL_CYCLES = 3;

  // shift amount bits for one element
  localparam int SHAMT_W = $clog2(WORD_W);

  // multiplier operand slice per stage and stage counter width
  localparam int MUL_CHUNK_W = (WORD_W + MUL_CYCLES - 1) / MUL_CYCLES;
  localparam int MUL_CNT_W = $clog2(MUL_CYCLES);

  // functional unit of a beat
  typedef enum logic [1:0] {
    ALU  = 2'd0,
    MUL  = 2'd1,
    MASK = 2'd2,
    LSU  = 2'd3
  } fu_t;

  // alu operations, computed as vs2 op vs1
  typedef enum logic [3:0] {
    ADD = 4'd0,
    SUB = 4'd1,
    AND = 4'd2,
    OR  = 4'd3,
    XOR = 4'd4,
    SLL = 4'd5,
    SRL = 4'd6,
    // signed compare
    MIN = 4'd7,
    MAX = 4'd8
  } aluop_t;

  // operand source
  typedef enum logic [1:0] {
    // per-lane vector register
    V    = 2'd0,
    // immediate, same for both lanes
    I    = 2'd1,
    // scalar register, same for both lanes
    X    = 2'd2,
    NONE = 2'd3
  } src_t;

  // element offset inside the destination register group
  typedef logic [OFFSET_W-1:0] offset_t;

endpackage

// ==== design/vector_lane.sv ====
//==========================================================================
// vector lane
// one element per beat: single-cycle alu, element address adder and
// a multi-cycle multiplier, with the result picked by functional unit
//==========================================================================
`timescale 1ns/1ps

module vector_lane (
  input  logic                          CLK,
  input  logic                          nRST,
  input  rv32v_pkg::fu_t                fu_type,
  input  rv32v_pkg::aluop_t             aluop,
  input  logic                          start_mul,
  input  logic [rv32v_pkg::WORD_W-1:0]  vs1_data,
  input  logic [rv32v_pkg::WORD_W-1:0]  vs2_data,
  input  logic [rv32v_pkg::WORD_W-1:0]  addr_base,
  input  logic [rv32v_pkg::WORD_W-1:0]  addr_step,
  input  logic [rv32v_pkg::WORD_W-1:0]  iota_res,
  output logic [rv32v_pkg::WORD_W-1:0]  out_addr,
  output logic [rv32v_pkg::WORD_W-1:0]  lane_result,
  output logic                          mul_busy,
  output logic                          mul_done
);
  import rv32v_pkg::*;

  logic [WORD_W-1:0] alu_res;
  logic [WORD_W-1:0] mul_res;
  logic [SHAMT_W-1:0] shamt;
  logic              vs2_lt;

  assign shamt  = vs1_data[SHAMT_W-1:0];
  // signed compare for min and max
  assign vs2_lt = $signed(vs2_data) < $signed(vs1_data);

  always_comb begin
    case (aluop)
      ADD: begin
        alu_res = vs2_data + vs1_data;
      end
      SUB: begin
        alu_res = vs2_data - vs1_data;
      end
      AND: begin
        alu_res = vs2_data & vs1_data;
      end
      OR: begin
        alu_res = vs2_data | vs1_data;
      end
      XOR: begin
        alu_res = vs2_data ^ vs1_data;
      end
      SLL: begin
        alu_res = vs2_data << shamt;
      end
      SRL: begin
        alu_res = vs2_data >> shamt;
      end
      MIN: begin
        alu_res = vs2_lt ? vs2_data : vs1_data;
      end
      MAX: begin
        alu_res = vs2_lt ? vs1_data : vs2_data;
      end
      default: begin
        alu_res = '0;
      end
    endcase
  end

  // element address, chained across lanes by the stage
  assign out_addr = addr_base + addr_step;

  lane_multiplier mul (
    .CLK     (CLK),
    .nRST    (nRST),
    .start   (start_mul),
    .a       (vs2_data),
    .b       (vs1_data),
    .product (mul_res),
    .busy    (mul_busy),
    .done    (mul_done)
  );

  always_comb begin
    case (fu_type)
      MUL: begin
        lane_result = mul_res;
      end
      MASK: begin
        lane_result = iota_res;
      end
      LSU: begin
        lane_result = out_addr;
      end
      default: begin
        lane_result = alu_res;
      end
    endcase
  end

endmodule

// ==== project.f ====
+incdir+bench
design/rv32v_pkg.sv
design/lane_multiplier.sv
design/vector_lane.sv
design/iota_logic.sv
design/rv32v_execute_stage.sv
bench/tb_rv32v_execute_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f project.f --top-module tb_rv32v_execute_stage -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TEST PASSED" sim.log; then
  exit 0
else
  echo "simulation reported failure"
  exit 1
fi
